// File: energy_monitor_pkg.sv
// sizes, controller state enum, config/spin/weight-row/partial structs for the energy monitor
package energy_monitor_pkg;

    localparam int NUM_SPIN  = 16; // spins per configuration
    localparam int WEIGHT_W  = 4;  // signed coupling and field width
    localparam int ROW_IDX_W = 4;  // row index width
    localparam int ENERGY_W  = 16; // signed energy width
    localparam int CNT_W     = ROW_IDX_W + 1; // row count, one past the last index

    // controller states
    typedef enum logic [1:0] {
        SLEEP   = 2'b00,
        IDLE    = 2'b01,
        LOAD    = 2'b10,
        COMPUTE = 2'b11
    } state_t;

    // configuration word
    typedef struct packed {
        logic [ROW_IDX_W-1:0] n_rows;   // active rows minus one
        logic                 field_en; // include h term
    } config_t;

    // bit 1 is spin +1, bit 0 is spin -1
    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    // one row of the coupling matrix plus the local field of that row
    typedef struct packed {
        logic [NUM_SPIN-1:0][WEIGHT_W-1:0] coupling; // J(i,j), signed entries
        logic signed [WEIGHT_W-1:0]        field;    // h(i)
    } weight_row_t;

    // row energy handed to the accumulator
    typedef struct packed {
        logic signed [ENERGY_W-1:0] value; // s(i) * local field
        logic                       add;   // one-cycle add strobe
    } partial_t;

endpackage

// File: logic_ctrl.sv
// controller FSM: sleep/idle/load/compute sequencing, handshake readies and energy valid
`timescale 1ns/1ps

module logic_ctrl import energy_monitor_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,        // synchronous, active low
    input  logic   en_i,           // level enable
    input  logic   debug_en_i,     // freezes the state

    input  logic   config_valid_i,
    output logic   config_ready_o,

    input  logic   spin_valid_i,
    output logic   spin_ready_o,

    input  logic   weight_valid_i,
    output logic   weight_ready_o,

    input  logic   counter_ready_i, // last active row accepted
    input  logic   cmpt_done_i,     // row energy accumulated

    output logic   energy_valid_o,
    input  logic   energy_ready_i,

    output state_t state_o
);

    state_t state_q;
    state_t state_d;
    logic   accept_ok;  // new transfers allowed this cycle

    assign accept_ok = en_i && !debug_en_i;

    // config is only taken alongside spins in IDLE
    assign config_ready_o = (state_q == IDLE) && accept_ok;
    assign spin_ready_o   = (state_q == IDLE) && accept_ok;
    assign weight_ready_o = (state_q == LOAD) && accept_ok;
    assign energy_valid_o = (state_q == COMPUTE) && cmpt_done_i && counter_ready_i;

    assign state_o = state_q;

    always_comb begin
        state_d = state_q;
        if (!en_i) begin
            state_d = SLEEP;
        end else if (!debug_en_i) begin
            case (state_q)
                SLEEP: begin
                    state_d = IDLE;
                end
                IDLE: begin
                    if (spin_valid_i && spin_ready_o) begin
                        state_d = LOAD;
                    end
                end
                LOAD: begin
                    if (weight_valid_i && weight_ready_o) begin
                        state_d = COMPUTE;
                    end
                end
                COMPUTE: begin
                    if (cmpt_done_i) begin
                        if (!counter_ready_i) begin
                            state_d = LOAD;  // more rows to come
                        end else if (energy_ready_i) begin
                            state_d = IDLE;  // result taken
                        end
                    end
                end
                default: begin
                    state_d = SLEEP;
                end
            endcase
        end else if (energy_valid_o && energy_ready_i) begin
            // a result already on offer still completes its transfer
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SLEEP;
        end else begin
            state_q <= state_d;
        end
    end

    // result stays offered until it is taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        energy_valid_o && !energy_ready_i && en_i |=> energy_valid_o && state_q == COMPUTE);

    // every weight row starts a new computation with done cleared
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        weight_valid_i && weight_ready_o |=> (state_q == COMPUTE) && !cmpt_done_i);

endmodule

// File: step_counter.sv
// row counter: holds the configuration, counts accepted weight rows, flags the last row
`timescale 1ns/1ps

module step_counter import energy_monitor_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 config_load_i,  // config handshake
    input  config_t              config_i,
    input  logic                 clear_i,        // new spin vector or sleep
    input  logic                 step_i,         // weight handshake
    output logic [ROW_IDX_W-1:0] row_idx_o,
    output logic                 field_en_o,
    output logic                 counter_ready_o
);

    config_t          cfg_q;
    logic [CNT_W-1:0] count_q; // rows accepted so far

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
        end else if (config_load_i) begin
            cfg_q <= config_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign row_idx_o  = count_q[ROW_IDX_W-1:0]; // index of the next row to arrive
    assign field_en_o = cfg_q.field_en;

    // n_rows holds active rows minus one
    assign counter_ready_o = (count_q > CNT_W'(cfg_q.n_rows));

    // controller must not ask for a row past the last active one
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        step_i |-> !counter_ready_o);

endmodule

// File: partial_energy_calc.sv
// row energy unit: latches spins and one weight row, forms s(i) * (sum J(i,j) s(j) + h(i))
`timescale 1ns/1ps

module partial_energy_calc import energy_monitor_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 spin_load_i,  // spin handshake
    input  spin_vec_t            spin_i,
    input  logic                 row_load_i,   // weight handshake
    input  weight_row_t          weight_i,
    input  logic [ROW_IDX_W-1:0] row_idx_i,
    input  logic                 field_en_i,
    output partial_t             partial_o,
    output logic                 cmpt_done_o
);

    spin_vec_t                  spin_q;
    weight_row_t                row_q;
    logic [ROW_IDX_W-1:0]       idx_q;    // row index of row_q
    logic                       row_pend; // row captured, energy not yet formed
    logic signed [ENERGY_W-1:0] local_field;
    logic signed [ENERGY_W-1:0] row_energy;
    logic signed [ENERGY_W-1:0] value_q;
    logic                       add_q;
    logic                       done_q;

    // payload registers
    always_ff @(posedge clk_i) begin
        if (spin_load_i) begin
            spin_q <= spin_i;
        end
        if (row_load_i) begin
            row_q <= weight_i;
            idx_q <= row_idx_i;
        end
        value_q <= row_energy;
    end

    // sum of J(i,j) * s(j), with s(j) = +1 or -1
    always_comb begin
        local_field = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            if (spin_q[j]) begin
                local_field = local_field + $signed(row_q.coupling[j]);
            end else begin
                local_field = local_field - $signed(row_q.coupling[j]);
            end
        end
        if (field_en_i) begin
            local_field = local_field + $signed(row_q.field);
        end
    end

    assign row_energy = spin_q[idx_q] ? local_field : -local_field; // times s(i)

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            row_pend <= 1'b0;
            add_q    <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            row_pend <= row_load_i;
            add_q    <= row_pend;  // one-cycle strobe with value_q
            if (spin_load_i || row_load_i) begin
                done_q <= 1'b0;
            end else if (add_q) begin
                done_q <= 1'b1;    // rises with the accumulator update
            end
        end
    end

    assign partial_o.value = value_q;
    assign partial_o.add   = add_q;
    assign cmpt_done_o     = done_q;

endmodule

// File: energy_accumulator.sv
// signed energy accumulator: clears on a new spin vector, subtracts each row energy
`timescale 1ns/1ps

module energy_accumulator import energy_monitor_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       clear_i,   // spin handshake
    input  partial_t                   partial_i,
    output logic signed [ENERGY_W-1:0] energy_o
);

    logic signed [ENERGY_W-1:0] total_q;

    // H carries a leading minus, so row energies are subtracted
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            total_q <= '0;
        end else if (clear_i) begin
            total_q <= '0;
        end else if (partial_i.add) begin
            total_q <= total_q - partial_i.value;
        end
    end

    assign energy_o = total_q; // held between updates

    // a spin vector can only arrive once all rows have settled
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(clear_i && partial_i.add));

endmodule

// File: energy_monitor.sv
// energy monitor top: controller, row counter, row energy unit and accumulator
`timescale 1ns/1ps

module energy_monitor import energy_monitor_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       en_i,
    input  logic                       debug_en_i,

    input  logic                       config_valid_i,
    input  config_t                    config_i,
    output logic                       config_ready_o,

    input  logic                       spin_valid_i,
    input  spin_vec_t                  spin_i,
    output logic                       spin_ready_o,

    input  logic                       weight_valid_i,
    input  weight_row_t                weight_i,
    output logic                       weight_ready_o,

    output logic                       energy_valid_o,
    output logic signed [ENERGY_W-1:0] energy_o,
    input  logic                       energy_ready_i
);

    logic                 config_fire;
    logic                 spin_fire;
    logic                 weight_fire;
    logic                 counter_clear;
    logic                 counter_ready;
    logic                 cmpt_done;
    logic [ROW_IDX_W-1:0] row_idx;
    logic                 field_en;
    partial_t             partial;
    state_t               ctrl_state;

    assign config_fire   = config_valid_i && config_ready_o;
    assign spin_fire     = spin_valid_i && spin_ready_o;
    assign weight_fire   = weight_valid_i && weight_ready_o;
    assign counter_clear = spin_fire || (ctrl_state == SLEEP); // drop partial work on sleep

    logic_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .en_i            (en_i),
        .debug_en_i      (debug_en_i),
        .config_valid_i  (config_valid_i),
        .config_ready_o  (config_ready_o),
        .spin_valid_i    (spin_valid_i),
        .spin_ready_o    (spin_ready_o),
        .weight_valid_i  (weight_valid_i),
        .weight_ready_o  (weight_ready_o),
        .counter_ready_i (counter_ready),
        .cmpt_done_i     (cmpt_done),
        .energy_valid_o  (energy_valid_o),
        .energy_ready_i  (energy_ready_i),
        .state_o         (ctrl_state)
    );

    step_counter u_counter (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .config_load_i   (config_fire),
        .config_i        (config_i),
        .clear_i         (counter_clear),
        .step_i          (weight_fire),
        .row_idx_o       (row_idx),
        .field_en_o      (field_en),
        .counter_ready_o (counter_ready)
    );

    partial_energy_calc u_partial (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .spin_load_i (spin_fire),
        .spin_i      (spin_i),
        .row_load_i  (weight_fire),
        .weight_i    (weight_i),
        .row_idx_i   (row_idx),
        .field_en_i  (field_en),
        .partial_o   (partial),
        .cmpt_done_o (cmpt_done)
    );

    energy_accumulator u_acc (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .clear_i   (spin_fire),
        .partial_i (partial),
        .energy_o  (energy_o)
    );

endmodule

// File: tb_clock_gen.sv
// testbench clock source with a 20 ns period
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    localparam real HALF_PERIOD = 10.0; // ns

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

// File: tb_energy_monitor.sv
// testbench: case file reader, Ising energy model, handshake drivers, energy and level checks
`timescale 1ns/1ps

module tb_energy_monitor import energy_monitor_pkg::*; ();

    localparam int NUM_CASES  = 6;
    localparam int CASE_BASE  = NUM_SPIN;             // case words follow the weight rows
    localparam int MEM_WORDS  = NUM_SPIN + 4 * NUM_CASES;
    localparam int WAIT_LIMIT = 200;                  // cycles allowed per wait
    localparam int SEL_SPIN   = 0;
    localparam int SEL_WEIGHT = 1;
    localparam int SEL_ENERGY = 2;
    localparam int MODE_STALL = 1;                    // random energy_ready_i stalls
    localparam int MODE_DEBUG = 2;                    // debug holds while loading
    localparam int MODE_SLEEP = 3;                    // enable dropped mid-case first

    logic                       clk;
    logic                       rst_n;
    logic                       en;
    logic                       debug_en;
    logic                       config_valid;
    config_t                    cfg;
    logic                       config_ready;
    logic                       spin_valid;
    spin_vec_t                  spins;
    logic                       spin_ready;
    logic                       weight_valid;
    weight_row_t                weights;
    logic                       weight_ready;
    logic                       energy_valid;
    logic signed [ENERGY_W-1:0] energy;
    logic                       energy_ready;

    logic [$bits(weight_row_t)-1:0] case_mem [0:MEM_WORDS-1];
    weight_row_t                    matrix [0:NUM_SPIN-1];
    int                             error_count;
    int                             timeout_count;
    logic [31:0]                    lfsr;

    tb_clock_gen u_clk (
        .clk_o (clk)
    );

    energy_monitor uut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .en_i           (en),
        .debug_en_i     (debug_en),
        .config_valid_i (config_valid),
        .config_i       (cfg),
        .config_ready_o (config_ready),
        .spin_valid_i   (spin_valid),
        .spin_i         (spins),
        .spin_ready_o   (spin_ready),
        .weight_valid_i (weight_valid),
        .weight_i       (weights),
        .weight_ready_o (weight_ready),
        .energy_valid_o (energy_valid),
        .energy_o       (energy),
        .energy_ready_i (energy_ready)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lfsr[0];
    endfunction

    function automatic int spin_value(input logic b);
        return b ? 1 : -1; // bit 1 is +1
    endfunction

    // H = -sum_i s(i) * (sum_j J(i,j) s(j) + h(i) * field_en)
    function automatic int ising_energy(input config_t c, input spin_vec_t s);
        int total;
        int local_sum;
        total = 0;
        for (int i = 0; i <= int'(c.n_rows); i++) begin
            local_sum = c.field_en ? int'($signed(matrix[i].field)) : 0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                local_sum += spin_value(s[j]) * int'($signed(matrix[i].coupling[j]));
            end
            total += spin_value(s[i]) * local_sum;
        end
        return -total;
    endfunction

    function automatic logic watched(input int which);
        case (which)
            SEL_SPIN:   return spin_ready;
            SEL_WEIGHT: return weight_ready;
            default:    return energy_valid;
        endcase
    endfunction

    task automatic check_energy(input logic signed [ENERGY_W-1:0] got,
                                input logic signed [ENERGY_W-1:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("value errors: %0d, timeouts: %0d", error_count, timeout_count);
    endtask

    task automatic timeout_abort(input string what);
        timeout_count++;
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        report_counts();
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic wait_high(input int which, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!watched(which) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!watched(which)) begin
            timeout_abort(what);
        end
    endtask

    // config and spins offered together in IDLE
    task automatic start_case(input config_t c, input spin_vec_t s);
        @(posedge clk);
        cfg          <= c;
        config_valid <= 1'b1;
        spins        <= s;
        spin_valid   <= 1'b1;
        wait_high(SEL_SPIN, "spin_ready_o");
        check_level(config_ready, 1'b1, "config_ready_o with spin_ready_o");
        @(posedge clk); // transfer edge
        config_valid <= 1'b0;
        spin_valid   <= 1'b0;
    endtask

    // with pause, the row waits in LOAD under a debug hold of random length
    task automatic send_row(input int i, input logic pause);
        int span;
        span = 0;
        if (pause) begin
            span = 1;
            if (next_rand_bit()) begin
                span += 2;
            end
            if (next_rand_bit()) begin
                span += 1;
            end
            wait_high(SEL_WEIGHT, "weight_ready_o before debug hold");
        end
        @(posedge clk);
        weights      <= matrix[i];
        weight_valid <= 1'b1;
        if (pause) begin
            debug_en <= 1'b1;
            for (int n = 0; n < span; n++) begin
                @(negedge clk);
                check_level(weight_ready, 1'b0, "weight_ready_o during debug hold");
                @(posedge clk);
            end
            debug_en <= 1'b0;
        end
        wait_high(SEL_WEIGHT, "weight_ready_o");
        @(posedge clk);
        weight_valid <= 1'b0;
    endtask

    task automatic take_energy(input logic signed [ENERGY_W-1:0] exp, input logic stall);
        logic signed [ENERGY_W-1:0] held;
        logic                       go;
        int                         cycles;
        wait_high(SEL_ENERGY, "energy_valid_o");
        held = energy;
        check_energy(held, exp, "energy_o");
        go     = 1'b0;
        cycles = 0;
        while (!go && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            go = stall ? next_rand_bit() : 1'b1;
            energy_ready <= go;
            @(negedge clk); // result must hold until the DUT sees ready
            check_level(energy_valid, 1'b1, "energy_valid_o before transfer");
            check_energy(energy, held, "energy_o before transfer");
            cycles++;
        end
        if (!go) begin
            timeout_abort("energy transfer");
        end
        @(posedge clk); // transfer edge
        energy_ready <= 1'b0;
        @(negedge clk);
        check_level(energy_valid, 1'b0, "energy_valid_o after transfer");
        check_level(config_ready, 1'b1, "config_ready_o in idle");
        check_level(spin_ready, 1'b1, "spin_ready_o in idle");
    endtask

    // part of a case, then enable low mid-load
    task automatic drop_enable(input config_t c, input spin_vec_t s);
        start_case(c, s);
        for (int i = 0; i < 3; i++) begin
            send_row(i, 1'b0);
        end
        @(posedge clk);
        en <= 1'b0;
        repeat (3) @(negedge clk);
        check_level(config_ready, 1'b0, "config_ready_o in sleep");
        check_level(spin_ready, 1'b0, "spin_ready_o in sleep");
        check_level(weight_ready, 1'b0, "weight_ready_o in sleep");
        check_level(energy_valid, 1'b0, "energy_valid_o in sleep");
        @(posedge clk);
        en <= 1'b1;
    endtask

    task automatic run_case(input int k);
        int                         base;
        int                         mode;
        config_t                    c;
        spin_vec_t                  s;
        logic signed [ENERGY_W-1:0] exp;
        base = CASE_BASE + 4 * k;
        mode = int'(case_mem[base][3:0]);
        c    = case_mem[base + 1][$bits(config_t)-1:0];
        s    = case_mem[base + 2][NUM_SPIN-1:0];
        exp  = case_mem[base + 3][ENERGY_W-1:0];
        check_energy(exp, ENERGY_W'(ising_energy(c, s)), "case file energy vs model");
        if (mode == MODE_SLEEP) begin
            drop_enable(c, s);
        end
        start_case(c, s);
        for (int i = 0; i <= int'(c.n_rows); i++) begin
            send_row(i, mode == MODE_DEBUG);
        end
        take_energy(exp, mode == MODE_STALL);
    endtask

    initial begin
        error_count   = 0;
        timeout_count = 0;
        lfsr          = 32'd78620;
        rst_n         = 1'b0;
        en            = 1'b0;
        debug_en      = 1'b0;
        config_valid  = 1'b0;
        cfg           = '0;
        spin_valid    = 1'b0;
        spins         = '0;
        weight_valid  = 1'b0;
        weights       = '0;
        energy_ready  = 1'b0;
        $readmemh("energy_cases.txt", case_mem);
        for (int i = 0; i < NUM_SPIN; i++) begin
            matrix[i] = case_mem[i];
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_level(config_ready, 1'b0, "config_ready_o in reset");
        check_level(spin_ready, 1'b0, "spin_ready_o in reset");
        check_level(weight_ready, 1'b0, "weight_ready_o in reset");
        check_level(energy_valid, 1'b0, "energy_valid_o in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(k);
        end
        report_counts();
        if (error_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: energy_cases.txt
// lines 1-16: weight row i as J(i,15)..J(i,0) then h(i), 4-bit signed hex digits
// after that one line per case: mode (0 plain, 1 stall, 2 debug, 3 sleep), config, spins, H
22222222111111113
33333333FFFFFFFFE
FFFFFFFF222222221
11111111EEEEEEEE4
0000000033333333F
DDDDDDDD000000002
22222222DDDDDDDD0
1111111111111111C
EEEEEEEE222222225
FFFFFFFFFFFFFFFFD
11111111444444441
2222222200000000E
33333333EEEEEEEE6
CCCCCCCC11111111F
22222222333333332
00000000FFFFFFFFB
// all 16 rows with field, then without, then rows 0-5 only
0 1F 6DF7 FF8C
0 1E 6DF7 FF8E
0 0B 6DF7 FFD7
// stalled result, debug holds over rows 0-9, enable drop before rows 0-11
1 1F 9E21 FFEA
2 13 9E21 0005
3 16 9E21 000E

// File: energy_monitor.f
energy_monitor_pkg.sv
logic_ctrl.sv
step_counter.sv
partial_energy_calc.sv
energy_accumulator.sv
energy_monitor.sv
tb_clock_gen.sv
tb_energy_monitor.sv
